/* design/cpuPkg.sv */
//**************************************
// Shared widths and encodings for the multicycle RV32I subset core.
// Only lw, sw, beq, addi and add/sub/and/or/slt are decoded.
// textBase is both the reset PC and the base of the unified memory.
//**************************************
package cpuPkg;

    localparam int xlen     = 32;
    localparam int regCount = 32;
    localparam int memWords = 256;

    typedef logic [xlen-1:0]               wordT;
    typedef logic [$clog2(regCount)-1:0]   regAddrT;
    typedef logic [$clog2(memWords)-1:0]   memIndexT;

    localparam wordT textBase = 32'h0040_0000;

    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opRtype  = 7'b0110011,
        opItype  = 7'b0010011,
        opBranch = 7'b1100011
    } opcodeT;

    typedef enum logic [2:0] {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluAnd = 3'b010,
        aluOr  = 3'b011,
        aluSlt = 3'b101
    } aluOpT;

    typedef enum logic [1:0] {immI = 2'b00, immS = 2'b01, immB = 2'b10} immSrcT;
    typedef enum logic [1:0] {srcPc = 2'b00, srcOldPc = 2'b01, srcRegA = 2'b10} srcASelT;
    typedef enum logic [1:0] {srcRegB = 2'b00, srcImm = 2'b01, srcFour = 2'b10} srcBSelT;
    typedef enum logic [1:0] {
        resAluOut    = 2'b00,
        resMemData   = 2'b01,
        resAluResult = 2'b10
    } resultSelT;

    typedef enum logic [3:0] {
        sFetch, sDecode, sMemAdr, sMemRead, sMemWb,
        sMemWrite, sExecR, sExecI, sAluWb, sBeq
    } fsmStateT;

endpackage

/* design/alu.sv */
//**************************************
// Shared ALU, five operations.
// zero is the only flag; slt is signed.
//**************************************
`timescale 1ns/1ps

module alu (
    input  cpuPkg::aluOpT  op,
    input  cpuPkg::wordT   a,
    input  cpuPkg::wordT   b,
    output cpuPkg::wordT   y,
    output logic           zero
);
    import cpuPkg::*;

    logic lessThan;

    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            aluAdd:  y = a + b;
            aluSub:  y = a - b;
            aluAnd:  y = a & b;
            aluOr:   y = a | b;
            aluSlt:  y = {{(xlen-1){1'b0}}, lessThan};
            default: y = '0;
        endcase
    end

    assign zero = (y == '0); // beq uses sub

    always_comb begin
        if (!$isunknown(op)) begin
            opDefined: assert (op inside {aluAdd, aluSub, aluAnd, aluOr, aluSlt})
                else $error("alu received undefined op %b", op);
        end
    end

endmodule

/* design/regFile.sv */
//**************************************
// 32 x 32 register file, x0 reads as zero.
// Writes to x0 land in the array but are never visible.
//**************************************
`timescale 1ns/1ps

module regFile (
    input  logic             clk,
    input  logic             rst,
    input  logic             we,
    input  cpuPkg::regAddrT  rs1,
    input  cpuPkg::regAddrT  rs2,
    input  cpuPkg::regAddrT  rd,
    input  cpuPkg::wordT     wd,
    output cpuPkg::wordT     rd1,
    output cpuPkg::wordT     rd2
);
    import cpuPkg::*;

    wordT regs [regCount];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[rd] <= wd;
        end
    end

    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* design/unifiedMemory.sv */
//**************************************
// Unified instruction/data memory, word addressed from textBase.
// Load port writes only while rst is high; reset keeps the contents.
// Addresses outside the array wrap on the word index.
//**************************************
`timescale 1ns/1ps

module unifiedMemory (
    input  logic              clk,
    input  logic              rst,
    input  logic              loadEn,
    input  cpuPkg::memIndexT  loadAddr,
    input  cpuPkg::wordT      loadData,
    input  logic              we,
    input  cpuPkg::wordT      adr,
    input  cpuPkg::wordT      writeData,
    output cpuPkg::wordT      readData
);
    import cpuPkg::*;

    wordT     mem [memWords];
    wordT     offset;
    memIndexT wordIdx;

    assign offset   = adr - textBase;
    assign wordIdx  = memIndexT'(offset >> 2); // byte offset to word index
    assign readData = mem[wordIdx];

    always_ff @(posedge clk) begin
        if (rst) begin
            if (loadEn) begin
                mem[loadAddr] <= loadData; // boot image
            end
        end else if (we) begin
            mem[wordIdx] <= writeData;
        end
    end

    loadOnlyInReset: assert property (@(posedge clk) loadEn |-> rst)
        else $error("memory load attempted outside reset");

endmodule

/* design/controlFsm.sv */
//**************************************
// Multicycle sequencer for the supported subset.
// Unknown opcodes return to fetch after decode.
// Branch decision is folded into pcWrite.
//**************************************
`timescale 1ns/1ps

module controlFsm (
    input  logic               clk,
    input  logic               rst,
    input  cpuPkg::opcodeT     opcode,
    input  logic [2:0]         funct3,
    input  logic               funct7b5,
    input  logic               zero,
    output logic               pcWrite,
    output logic               adrSrc,
    output logic               memWrite,
    output logic               irWrite,
    output logic               regWrite,
    output cpuPkg::resultSelT  resultSel,
    output cpuPkg::aluOpT      aluOp,
    output cpuPkg::srcASelT    srcASel,
    output cpuPkg::srcBSelT    srcBSel,
    output cpuPkg::immSrcT     immSrc
);
    import cpuPkg::*;

    fsmStateT state;
    fsmStateT nextState;
    aluOpT    aluDec;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sFetch;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        case (state)
            sFetch:  nextState = sDecode;
            sDecode: begin
                case (opcode)
                    opLoad, opStore: nextState = sMemAdr;
                    opRtype:         nextState = sExecR;
                    opItype:         nextState = sExecI;
                    opBranch:        nextState = sBeq;
                    default:         nextState = sFetch;
                endcase
            end
            sMemAdr:  nextState = (opcode == opLoad) ? sMemRead : sMemWrite;
            sMemRead: nextState = sMemWb;
            sExecR:   nextState = sAluWb;
            sExecI:   nextState = sAluWb;
            default:  nextState = sFetch; // wb, store and beq end here
        endcase
    end

    // sub only for R-type, addi with imm[10] set stays add
    always_comb begin
        case (funct3)
            3'b000:  aluDec = (opcode[5] && funct7b5) ? aluSub : aluAdd;
            3'b010:  aluDec = aluSlt;
            3'b110:  aluDec = aluOr;
            3'b111:  aluDec = aluAnd;
            default: aluDec = aluAdd;
        endcase
    end

    always_comb begin
        case (opcode)
            opStore:  immSrc = immS;
            opBranch: immSrc = immB;
            default:  immSrc = immI;
        endcase
    end

    always_comb begin
        pcWrite   = 1'b0;
        adrSrc    = 1'b0;
        memWrite  = 1'b0;
        irWrite   = 1'b0;
        regWrite  = 1'b0;
        resultSel = resAluOut;
        aluOp     = aluAdd;
        srcASel   = srcPc;
        srcBSel   = srcRegB;
        case (state)
            sFetch: begin
                irWrite   = 1'b1;
                pcWrite   = 1'b1;
                srcBSel   = srcFour; // pc + 4
                resultSel = resAluResult;
            end
            sDecode: begin
                srcASel = srcOldPc; // branch target into aluOut
                srcBSel = srcImm;
            end
            sMemAdr: begin
                srcASel = srcRegA;
                srcBSel = srcImm;
            end
            sMemRead: adrSrc = 1'b1;
            sMemWb: begin
                regWrite  = 1'b1;
                resultSel = resMemData;
            end
            sMemWrite: begin
                adrSrc   = 1'b1;
                memWrite = 1'b1;
            end
            sExecR: begin
                srcASel = srcRegA;
                aluOp   = aluDec;
            end
            sExecI: begin
                srcASel = srcRegA;
                srcBSel = srcImm;
                aluOp   = aluDec;
            end
            sAluWb: regWrite = 1'b1;
            sBeq: begin
                srcASel = srcRegA;
                aluOp   = aluSub;
                pcWrite = zero; // taken loads aluOut
            end
            default: ;
        endcase
    end

    noWriteClash: assert property (@(posedge clk) disable iff (rst) !(memWrite && regWrite))
        else $error("memory and register write in the same cycle");

    fetchThenDecode: assert property (@(posedge clk) disable iff (rst)
        irWrite |-> (state == sFetch) ##1 (state == sDecode))
        else $error("instruction register loaded outside fetch");

endmodule

/* design/datapath.sv */
//**************************************
// Multicycle datapath with one shared ALU.
// Operand, data and ALU output registers load every cycle.
// PC resets to textBase; branch decision comes in on pcWrite.
//**************************************
`timescale 1ns/1ps

module datapath (
    input  logic               clk,
    input  logic               rst,
    input  logic               pcWrite,
    input  logic               adrSrc,
    input  logic               irWrite,
    input  logic               regWrite,
    input  cpuPkg::resultSelT  resultSel,
    input  cpuPkg::aluOpT      aluOp,
    input  cpuPkg::srcASelT    srcASel,
    input  cpuPkg::srcBSelT    srcBSel,
    input  cpuPkg::immSrcT     immSrc,
    input  cpuPkg::wordT       readData,
    output cpuPkg::opcodeT     opcode,
    output logic [2:0]         funct3,
    output logic               funct7b5,
    output logic               zero,
    output cpuPkg::wordT       pc,
    output cpuPkg::wordT       instr,
    output cpuPkg::wordT       adr,
    output cpuPkg::wordT       writeData,
    output cpuPkg::wordT       result,
    output cpuPkg::regAddrT    rdAddr
);
    import cpuPkg::*;

    wordT oldPc;
    wordT rd1;
    wordT rd2;
    wordT aReg;
    wordT bReg;
    wordT immExt;
    wordT srcA;
    wordT srcB;
    wordT aluResult;
    wordT aluOut;
    wordT memData;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc    <= textBase;
            instr <= '0;
        end else begin
            if (pcWrite) begin
                pc <= result;
            end
            if (irWrite) begin
                instr <= readData;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (irWrite) begin
            oldPc <= pc; // base for the branch target
        end
        aReg    <= rd1;
        bReg    <= rd2;
        aluOut  <= aluResult;
        memData <= readData;
    end

    assign opcode    = opcodeT'(instr[6:0]);
    assign funct3    = instr[14:12];
    assign funct7b5  = instr[30];
    assign rdAddr    = instr[11:7];
    assign writeData = bReg;

    regFile u_regFile (
        .clk (clk),
        .rst (rst),
        .we  (regWrite),
        .rs1 (instr[19:15]),
        .rs2 (instr[24:20]),
        .rd  (rdAddr),
        .wd  (result),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    always_comb begin
        case (immSrc)
            immS:    immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB:    immExt = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            default: immExt = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    always_comb begin
        case (srcASel)
            srcOldPc: srcA = oldPc;
            srcRegA:  srcA = aReg;
            default:  srcA = pc;
        endcase
    end

    always_comb begin
        case (srcBSel)
            srcImm:  srcB = immExt;
            srcFour: srcB = 32'd4;
            default: srcB = bReg;
        endcase
    end

    alu u_alu (
        .op   (aluOp),
        .a    (srcA),
        .b    (srcB),
        .y    (aluResult),
        .zero (zero)
    );

    always_comb begin
        case (resultSel)
            resMemData:   result = memData;
            resAluResult: result = aluResult;
            default:      result = aluOut;
        endcase
    end

    assign adr = adrSrc ? result : pc; // data access or fetch

endmodule

/* design/cpuTop.sv */
//**************************************
// Multicycle RV32I subset core with unified memory.
// Program is loaded through the load port while rst is high.
// Observation ports are valid only in their enable cycles.
//**************************************
`timescale 1ns/1ps

module cpuTop (
    input  logic              clk,
    input  logic              rst,
    input  logic              loadEn,
    input  cpuPkg::memIndexT  loadAddr,
    input  cpuPkg::wordT      loadData,
    output cpuPkg::wordT      pc,
    output cpuPkg::wordT      instr,
    output logic              regWriteEn,
    output cpuPkg::regAddrT   regWriteAddr,
    output cpuPkg::wordT      regWriteData,
    output logic              memWriteEn,
    output cpuPkg::wordT      memWriteAddr,
    output cpuPkg::wordT      memWriteData
);
    import cpuPkg::*;

    wordT      readData;
    opcodeT    opcode;
    logic [2:0] funct3;
    logic      funct7b5;
    logic      zero;
    logic      pcWrite;
    logic      adrSrc;
    logic      irWrite;
    resultSelT resultSel;
    aluOpT     aluOp;
    srcASelT   srcASel;
    srcBSelT   srcBSel;
    immSrcT    immSrc;

    unifiedMemory u_memory (
        .clk       (clk),
        .rst       (rst),
        .loadEn    (loadEn),
        .loadAddr  (loadAddr),
        .loadData  (loadData),
        .we        (memWriteEn),
        .adr       (memWriteAddr), // shared address bus
        .writeData (memWriteData),
        .readData  (readData)
    );

    controlFsm u_control (
        .clk       (clk),
        .rst       (rst),
        .opcode    (opcode),
        .funct3    (funct3),
        .funct7b5  (funct7b5),
        .zero      (zero),
        .pcWrite   (pcWrite),
        .adrSrc    (adrSrc),
        .memWrite  (memWriteEn),
        .irWrite   (irWrite),
        .regWrite  (regWriteEn),
        .resultSel (resultSel),
        .aluOp     (aluOp),
        .srcASel   (srcASel),
        .srcBSel   (srcBSel),
        .immSrc    (immSrc)
    );

    datapath u_datapath (
        .clk       (clk),
        .rst       (rst),
        .pcWrite   (pcWrite),
        .adrSrc    (adrSrc),
        .irWrite   (irWrite),
        .regWrite  (regWriteEn),
        .resultSel (resultSel),
        .aluOp     (aluOp),
        .srcASel   (srcASel),
        .srcBSel   (srcBSel),
        .immSrc    (immSrc),
        .readData  (readData),
        .opcode    (opcode),
        .funct3    (funct3),
        .funct7b5  (funct7b5),
        .zero      (zero),
        .pc        (pc),
        .instr     (instr),
        .adr       (memWriteAddr),
        .writeData (memWriteData),
        .result    (regWriteData),
        .rdAddr    (regWriteAddr)
    );

endmodule

/* tb/cpuTb.sv */
//****************************************
// Directed tests for cpuTop against an ISA model.
// Every program ends in beq x0,x0,0, which spins without writes.
// Data addresses wrap onto the 256-word memory like the DUT.
//****************************************
`timescale 1ns/1ps

module cpuTb;
    import cpuPkg::*;

    localparam int maxWait = 40; // cycles between two writes

    logic     clk;
    logic     rst;
    logic     loadEn;
    memIndexT loadAddr;
    wordT     loadData;
    wordT     pc;
    wordT     instr;
    logic     regWriteEn;
    regAddrT  regWriteAddr;
    wordT     regWriteData;
    logic     memWriteEn;
    wordT     memWriteAddr;
    wordT     memWriteData;

    int   cycleCount = 0;
    int   seed;
    wordT prog[$];
    bit   evIsMem[$]; // expected writes in order
    wordT evAddr[$];
    wordT evData[$];
    int   evCycle[$];
    wordT evInstr[$];

    cpuTop u_cpuTop (
        .clk          (clk),
        .rst          (rst),
        .loadEn       (loadEn),
        .loadAddr     (loadAddr),
        .loadData     (loadData),
        .pc           (pc),
        .instr        (instr),
        .regWriteEn   (regWriteEn),
        .regWriteAddr (regWriteAddr),
        .regWriteData (regWriteData),
        .memWriteEn   (memWriteEn),
        .memWriteAddr (memWriteAddr),
        .memWriteData (memWriteData)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    function automatic wordT rTypeInstr(input logic f7b5, input logic [2:0] f3,
                                        input int rd, input int rs1, input int rs2);
        return {1'b0, f7b5, 5'b0, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic wordT addiInstr(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic wordT loadInstr(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic wordT storeInstr(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic wordT branchInstr(input int rs1, input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic wordT iImm(input wordT ins);
        return {{20{ins[31]}}, ins[31:20]};
    endfunction

    function automatic wordT sImm(input wordT ins);
        return {{20{ins[31]}}, ins[31:25], ins[11:7]};
    endfunction

    function automatic wordT bImm(input wordT ins);
        return {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    endfunction

    function automatic int wordIndex(input wordT addr);
        return int'(memIndexT'((addr - textBase) >> 2));
    endfunction

    function automatic wordT aluModel(input logic [2:0] f3, input logic sub,
                                      input wordT a, input wordT b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return '0;
        endcase
    endfunction

    task automatic addEvent(input bit isMem, input wordT addr, input wordT data,
                            input int cyc, input wordT ins);
        evIsMem.push_back(isMem);
        evAddr.push_back(addr);
        evData.push_back(data);
        evCycle.push_back(cyc);
        evInstr.push_back(ins);
    endtask

    // runs the program on the ISA model, cycle numbers count from the first fetch
    task automatic buildModel();
        wordT regsM [regCount];
        wordT memM [memWords];
        wordT pcM;
        wordT ins;
        wordT a;
        wordT b;
        wordT val;
        wordT addr;
        int   cyc;
        bit   done;
        evIsMem.delete();
        evAddr.delete();
        evData.delete();
        evCycle.delete();
        evInstr.delete();
        foreach (regsM[i]) regsM[i] = '0;
        foreach (memM[i]) memM[i] = '0;
        foreach (prog[i]) memM[i] = prog[i];
        pcM  = textBase;
        cyc  = 0;
        done = 1'b0;
        for (int step = 0; step < 300 && !done; step++) begin
            ins = memM[wordIndex(pcM)];
            a   = regsM[ins[19:15]];
            b   = regsM[ins[24:20]];
            case (ins[6:0])
                opRtype, opItype: begin
                    if (ins[6:0] == opRtype) begin
                        val = aluModel(ins[14:12], ins[30], a, b);
                    end else begin
                        val = aluModel(ins[14:12], 1'b0, a, iImm(ins)); // no subi
                    end
                    addEvent(1'b0, wordT'(ins[11:7]), val, cyc + 3, ins);
                    if (ins[11:7] != 5'd0) regsM[ins[11:7]] = val;
                    cyc += 4;
                end
                opLoad: begin
                    addr = a + iImm(ins);
                    val  = memM[wordIndex(addr)];
                    addEvent(1'b0, wordT'(ins[11:7]), val, cyc + 4, ins);
                    if (ins[11:7] != 5'd0) regsM[ins[11:7]] = val;
                    cyc += 5;
                end
                opStore: begin
                    addr = a + sImm(ins);
                    addEvent(1'b1, addr, b, cyc + 3, ins);
                    memM[wordIndex(addr)] = b;
                    cyc += 4;
                end
                opBranch: begin
                    done = (a == b) && (bImm(ins) == '0); // spin loop reached
                    cyc += 3;
                end
                default: cyc += 2;
            endcase
            if (ins[6:0] == opBranch && a == b) begin
                pcM = pcM + bImm(ins);
            end else begin
                pcM = pcM + 4;
            end
        end
    endtask

    task automatic checkValue(input wordT actual, input wordT expected, input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s, got %h expected %h", $time, what, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic waitWrite(output bit isMem);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!regWriteEn && !memWriteEn && waited < maxWait) begin
            @(negedge clk);
            waited++;
        end
        if (!regWriteEn && !memWriteEn) begin
            $display("timeout: no register or memory write within %0d cycles", maxWait);
            $display("SOME TESTS FAILED");
            $fatal(1, "write timeout");
        end else begin
            isMem = memWriteEn;
        end
    endtask

    task automatic runProgram(input string name);
        bit    isMem;
        int    startCycle;
        int    atCycle;
        string tag;
        prog.push_back(branchInstr(0, 0, 0));
        buildModel();
        rst = 1'b1;
        foreach (prog[i]) begin
            @(negedge clk);
            loadEn   = 1'b1;
            loadAddr = memIndexT'(i);
            loadData = prog[i];
        end
        @(negedge clk);
        loadEn = 1'b0;
        repeat (2) @(negedge clk);
        checkValue(pc, textBase, {name, " pc after reset"});
        checkValue({31'b0, regWriteEn}, '0, {name, " regWriteEn in reset"});
        checkValue({31'b0, memWriteEn}, '0, {name, " memWriteEn in reset"});
        rst = 1'b0;
        startCycle = cycleCount;
        for (int k = 0; k < evIsMem.size(); k++) begin
            waitWrite(isMem);
            atCycle = cycleCount - startCycle;
            tag = $sformatf("%s write %0d", name, k);
            checkValue({31'b0, isMem}, {31'b0, evIsMem[k]}, {tag, " kind"});
            checkValue(instr, evInstr[k], {tag, " instruction"});
            if (isMem) begin
                checkValue(memWriteAddr, evAddr[k], {tag, " store address"});
                checkValue(memWriteData, evData[k], {tag, " store data"});
            end else begin
                checkValue(wordT'(regWriteAddr), evAddr[k], {tag, " register"});
                checkValue(regWriteData, evData[k], {tag, " register data"});
            end
            checkValue(wordT'(atCycle), wordT'(evCycle[k]), {tag, " cycle"});
        end
        repeat (12) begin
            @(negedge clk);
            checkValue({31'b0, regWriteEn | memWriteEn}, '0, {name, " write after end"});
        end
        prog.delete();
    endtask

    task automatic aluTest();
        prog.push_back(addiInstr(1, 0, 5));
        prog.push_back(addiInstr(2, 0, -3));
        prog.push_back(rTypeInstr(1'b0, 3'b000, 3, 1, 2)); // add
        prog.push_back(rTypeInstr(1'b1, 3'b000, 4, 1, 2)); // sub
        prog.push_back(rTypeInstr(1'b0, 3'b111, 5, 1, 2));
        prog.push_back(rTypeInstr(1'b0, 3'b110, 6, 1, 2));
        prog.push_back(rTypeInstr(1'b0, 3'b010, 7, 2, 1)); // -3 < 5
        prog.push_back(rTypeInstr(1'b0, 3'b010, 8, 1, 2));
        prog.push_back(rTypeInstr(1'b1, 3'b000, 9, 2, 1));
        prog.push_back(rTypeInstr(1'b0, 3'b010, 10, 9, 2)); // both negative
        runProgram("alu");
    endtask

    task automatic memoryTest();
        prog.push_back(addiInstr(1, 0, 'h200));
        prog.push_back(addiInstr(2, 0, -1234));
        prog.push_back(storeInstr(2, 1, 8));
        prog.push_back(loadInstr(3, 1, 8));
        prog.push_back(rTypeInstr(1'b0, 3'b000, 4, 3, 3));
        prog.push_back(storeInstr(4, 1, -4)); // negative offset
        prog.push_back(loadInstr(5, 1, -4));
        runProgram("memory");
    endtask

    task automatic branchTest();
        prog.push_back(addiInstr(1, 0, 7));
        prog.push_back(addiInstr(2, 0, 7));
        prog.push_back(branchInstr(1, 2, 8)); // taken, skips next
        prog.push_back(addiInstr(3, 0, 99));
        prog.push_back(addiInstr(4, 0, 1));
        prog.push_back(branchInstr(1, 4, 8)); // not taken
        prog.push_back(addiInstr(6, 6, 1));
        prog.push_back(branchInstr(6, 4, -4)); // backward once
        prog.push_back(addiInstr(5, 0, 2));
        runProgram("branch");
    endtask

    task automatic randomTest();
        wordT r;
        for (int i = 0; i < 24; i++) begin
            r = $random(seed);
            if (r[0]) begin
                prog.push_back(addiInstr(int'(r[4:2]), int'(r[7:5]), int'(r[19:8])));
            end else begin
                prog.push_back(rTypeInstr(1'b0, 3'b000, int'(r[4:2]), int'(r[7:5]),
                                          int'(r[10:8])));
            end
        end
        prog.push_back(addiInstr(0, 3, 77)); // x0 write is still visible
        prog.push_back(rTypeInstr(1'b0, 3'b000, 9, 0, 0));
        prog.push_back(addiInstr(10, 0, 0));
        runProgram("random");
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        seed     = 32'h74a6_01df;
        aluTest();
        memoryTest();
        branchTest();
        randomTest();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* vlog.f */
design/cpuPkg.sv
design/alu.sv
design/regFile.sv
design/unifiedMemory.sv
design/controlFsm.sv
design/datapath.sv
design/cpuTop.sv
tb/cpuTb.sv

/* run.sh */
#!/bin/sh
# compile and run cpuTb with Verilator, the log decides pass or fail
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module cpuTb -f vlog.f -o cpuSim \
    && ./obj_dir/cpuSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "ALL TESTS PASSED" sim.log && echo "simulation ok" || { echo "simulation failed"; exit 1; }
